// File: rtl/uopPkg.sv
// Micro-op splitter types for instruction class, phase, data-processing opcode and field constants
`default_nettype none

package uopPkg;

	// Instruction word layout
	localparam int instrWidth = 32;             // Fixed ARM-style word
	localparam int condTop = 31;                // Condition field MSB
	localparam int condLow = 28;                // Condition field LSB

	// Register codes used when rewriting operands
	localparam logic [3:0] rzReg = 4'b1111;     // Scratch register routed by regFileRz
	localparam logic [3:0] linkReg = 4'd14;     // Link register
	localparam logic [3:0] pcReg = 4'd15;       // Program counter as a source

	// Class of split an instruction needs, from the classifier
	typedef enum logic [3:0] {
		kindNone = 4'd0,                        // Pass through untouched
		kindRsr = 4'd1,                         // Register-shifted-register DP
		kindMulAccShort = 4'd2,                 // MLA
		kindMulAccLong = 4'd3,                  // UMLAL / SMLAL
		kindBranchLink = 4'd4,                  // BL
		kindLdStPostImm = 4'd5,                 // Post-index with immediate offset
		kindLdStPreImm = 4'd6,                  // Pre-index with writeback and immediate
		kindLdStPostReg = 4'd7,                 // Post-index with register offset
		kindLdStPreReg = 4'd8,                  // Pre-index with writeback and register offset
		kindStrReg = 4'd9                       // Register-offset store without writeback
	} uopKind;

	// Which half of a split is on the bus
	typedef enum logic {
		phaseFirst = 1'b0,                      // Also the idle phase
		phaseSecond = 1'b1
	} uopPhase;

	// Data-processing opcode field, bits 24..21
	typedef enum logic [3:0] {
		opMulShape = 4'b0000,                   // Multiply group without accumulate
		opSub = 4'b0010,
		opAdd = 4'b0100,
		opMov = 4'b1101
	} dpOpcode;

endpackage

`default_nettype wire

// File: rtl/uopClassifier.sv
// Decoder from an instruction word to the split class it needs
`timescale 1ns/1ps
`default_nettype none

module uopClassifier (
	input  logic [uopPkg::instrWidth-1:0] instr,
	output uopPkg::uopKind                kind
);
	import uopPkg::*;

	logic rsrForm;                              // DP with shift amount in a register
	logic mulAccForm;                           // Multiply with accumulate bit
	logic branchLinkForm;
	logic ldStForm;                             // Single load/store group
	logic [1:0] ipBits;                         // I and P bits of a load/store

	assign rsrForm = (instr[27:25] == 3'b000) && !instr[7] && instr[4];
	assign mulAccForm = instr[21] && (instr[7:4] == 4'b1001);
	assign branchLinkForm = (instr[27:24] == 4'b1011);
	assign ldStForm = (instr[27:26] == 2'b01);
	assign ipBits = instr[25:24];

	// RSR checked ahead of the multiply pattern
	always_comb begin
		kind = kindNone;
		if (rsrForm) begin
			kind = kindRsr;
		end else if (mulAccForm) begin
			kind = instr[23] ? kindMulAccLong : kindMulAccShort; // Bit 23 selects long
		end else if (branchLinkForm) begin
			kind = kindBranchLink;
		end else if (ldStForm) begin
			case (ipBits)
				2'b00: begin
					if (!instr[21]) begin
						kind = kindLdStPostImm; // Post-index with W clear
					end
				end
				2'b01: begin
					if (instr[21]) begin
						kind = kindLdStPreImm;  // Pre-index with "!"
					end
				end
				2'b10: begin
					if (!instr[21]) begin
						kind = kindLdStPostReg;
					end
				end
				2'b11: begin
					if (instr[21]) begin
						kind = kindLdStPreReg;
					end else if (!instr[20]) begin
						kind = kindStrReg;      // Store without writeback
					end
				end
				default: begin
					kind = kindNone;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// File: rtl/uopSequencer.sv
// Phase register and latched class of the split in flight
`timescale 1ns/1ps
`default_nettype none

module uopSequencer (
	input  logic            clk,
	input  logic            reset,
	input  logic            stallUop,          // Decode stage frozen
	input  uopPkg::uopKind  kind,              // Live class from the classifier
	output uopPkg::uopPhase phase,
	output uopPkg::uopKind  heldKind           // Class captured at the first micro-op
);
	import uopPkg::*;

	logic startSplit;                           // First micro-op leaves this cycle
	logic endSplit;                             // Second micro-op leaves this cycle

	assign startSplit = (phase == phaseFirst) && (kind != kindNone) && !stallUop;
	assign endSplit = (phase == phaseSecond) && !stallUop;

	// Phase steps only on unstalled edges
	always_ff @(posedge clk) begin
		if (reset) begin
			phase <= phaseFirst;
		end else if (startSplit) begin
			phase <= phaseSecond;
		end else if (endSplit) begin
			phase <= phaseFirst;
		end
	end

	// Class is held for the whole second phase so instr is not decoded again
	always_ff @(posedge clk) begin
		if (reset) begin
			heldKind <= kindNone;
		end else if (startSplit) begin
			heldKind <= kind;
		end
	end

endmodule

`default_nettype wire

// File: rtl/uopComposer.sv
// Micro-op word and control levels per class and phase
`timescale 1ns/1ps
`default_nettype none

module uopComposer (
	input  logic [uopPkg::instrWidth-1:0] instr,
	input  uopPkg::uopPhase               phase,
	input  uopPkg::uopKind                kind,      // Live class, used in phaseFirst
	input  uopPkg::uopKind                heldKind,  // Latched class, used in phaseSecond
	output logic [uopPkg::instrWidth-1:0] uopInstr,
	output logic                          instrMux,
	output logic                          noUpdateFlags,
	output logic                          uopStall,
	output logic [3:0]                    regFileRz,
	output logic                          prevRsrState,
	output logic                          keepV,
	output logic                          noRotate,
	output logic                          ldStRtype
);
	import uopPkg::*;

	uopKind activeKind;                         // Class that steers this cycle
	logic first;
	logic [condTop-condLow:0] cond;
	logic [3:0] rn;                             // Bits 19..16
	logic [3:0] rd;                             // Bits 15..12
	dpOpcode upOp;                              // ADD or SUB from the U bit
	logic [instrWidth-1:0] mulWord;
	logic [instrWidth-1:0] postAccess;
	logic [instrWidth-1:0] preAccess;
	logic [instrWidth-1:0] baseUpdate;

	assign first = (phase == phaseFirst);
	assign activeKind = first ? kind : heldKind;
	assign cond = instr[condTop:condLow];
	assign rn = instr[19:16];
	assign rd = instr[15:12];
	assign upOp = instr[23] ? opAdd : opSub;

	assign uopStall = first && (kind != kindNone); // Hold fetch during the first half
	assign instrMux = (activeKind != kindNone);

	// Plain MUL into Rz keeping the sign bit for the long forms
	assign mulWord = {cond, 3'b000, opMulShape | {2'b00, instr[22], 1'b0}, 1'b0,
		rzReg, 4'b0000, instr[11:0]};

	// Post-index access goes out as immediate form with zero offset
	assign postAccess = {cond, 3'b010, 1'b1, 1'b1, instr[22], 1'b0, instr[20],
		instr[19:12], 12'h000};

	// Pre-index access keeps its offset and leaves writeback to the second micro-op
	assign preAccess = {cond, 2'b01, instr[25], 1'b1, instr[23:22], 1'b0, instr[20],
		instr[19:0]};

	// Rn = Rn +/- offset with the DP immediate bit inverted from the load/store I bit
	assign baseUpdate = {cond, 2'b00, ~instr[25], upOp, 1'b0, rn, rn, instr[11:0]};

	always_comb begin
		uopInstr = instr;                       // Unsplit instructions pass unchanged
		noUpdateFlags = 1'b0;
		regFileRz = 4'b0000;
		prevRsrState = 1'b0;
		keepV = 1'b0;
		noRotate = 1'b0;
		ldStRtype = 1'b0;
		case (activeKind)
			kindRsr: begin
				if (first) begin
					uopInstr = {cond, 3'b000, opMov, 1'b0, 4'b0000, rzReg, instr[11:0]};
					noUpdateFlags = 1'b1;       // Shift result only with flags untouched
					regFileRz = 4'b1100;
				end else begin
					uopInstr = {instr[31:12], 8'h00, rzReg}; // Unshifted Rz source
					prevRsrState = 1'b1;
					regFileRz = 4'b0010;
				end
			end
			kindMulAccShort, kindMulAccLong: begin
				if (first) begin
					uopInstr = mulWord;
					keepV = 1'b1;
					regFileRz = 4'b1100;
				end else if (activeKind == kindMulAccShort) begin
					// Rd = Rz + Rn of the MLA
					uopInstr = {cond, 3'b000, opAdd, instr[20], rzReg, rn, 8'h00, rd};
					noUpdateFlags = 1'b1;
					regFileRz = 4'b0001;
				end else begin
					// Long multiply with the accumulate bit set
					uopInstr = {cond, 4'b0000, 1'b1, instr[22], 1'b1, instr[20], rn, rd, rd,
						4'b1001, rn};
					noUpdateFlags = 1'b1;
				end
			end
			kindBranchLink: begin
				if (first) begin
					uopInstr = {cond, 3'b000, opMov, 1'b0, 4'b0000, linkReg, 8'h00, pcReg};
				end else begin
					uopInstr = {instr[31:25], 1'b0, instr[23:0]}; // Link bit cleared
				end
			end
			kindLdStPostImm, kindLdStPostReg, kindLdStPreImm, kindLdStPreReg: begin
				if (first) begin
					if ((activeKind == kindLdStPostImm) || (activeKind == kindLdStPostReg)) begin
						uopInstr = postAccess;
					end else begin
						uopInstr = preAccess;
					end
				end else begin
					uopInstr = baseUpdate;
				end
				noUpdateFlags = 1'b1;
				noRotate = 1'b1;                // Offset carried raw in both halves
				ldStRtype = (activeKind == kindLdStPostReg) || (activeKind == kindLdStPreReg);
			end
			kindStrReg: begin
				if (first) begin
					uopInstr = {cond, 3'b000, upOp, 1'b0, rn, rzReg, instr[11:0]}; // Rz = address
					regFileRz = 4'b0100;
				end else begin
					uopInstr = {cond, 3'b010, instr[24:20], rzReg, rd, 12'h000}; // Store via Rz
					regFileRz = 4'b0001;
				end
				noUpdateFlags = 1'b1;
			end
			default: begin
				uopInstr = instr;
			end
		endcase
	end

endmodule

`default_nettype wire

// File: rtl/microOpUnit.sv
// Top level joining classifier, sequencer and composer
`timescale 1ns/1ps
`default_nettype none

module microOpUnit (
	input  logic                          clk,
	input  logic                          reset,
	input  logic [uopPkg::instrWidth-1:0] instr,        // Held steady while uopStall
	input  logic                          stallUop,
	output logic [uopPkg::instrWidth-1:0] uopInstr,
	output logic                          instrMux,
	output logic                          noUpdateFlags,
	output logic                          uopStall,
	output logic [3:0]                    regFileRz,
	output logic                          prevRsrState,
	output logic                          keepV,
	output logic                          noRotate,
	output logic                          ldStRtype
);
	import uopPkg::*;

	uopKind kind;                               // Live decode
	uopKind heldKind;                           // Latched at first micro-op
	uopPhase phase;

	uopClassifier classifier (
		.instr (instr),
		.kind  (kind)
	);

	uopSequencer sequencer (
		.clk      (clk),
		.reset    (reset),
		.stallUop (stallUop),
		.kind     (kind),
		.phase    (phase),
		.heldKind (heldKind)
	);

	// Sits beside the sequencer register that steers it
	uopComposer composer (
		.instr         (instr),
		.phase         (phase),
		.kind          (kind),
		.heldKind      (heldKind),
		.uopInstr      (uopInstr),
		.instrMux      (instrMux),
		.noUpdateFlags (noUpdateFlags),
		.uopStall      (uopStall),
		.regFileRz     (regFileRz),
		.prevRsrState  (prevRsrState),
		.keepV         (keepV),
		.noRotate      (noRotate),
		.ldStRtype     (ldStRtype)
	);

endmodule

`default_nettype wire

// File: testbench/microOpUnit_checker.sv
// Bound assertions on uopStall, instrMux and phase under stallUop
`timescale 1ns/1ps
`default_nettype none

module microOpUnitChecker (
	input logic            clk,
	input logic            reset,
	input logic            stallUop,
	input logic            uopStall,
	input logic            instrMux,
	input uopPkg::uopPhase phase            // Sequencer phase inside the DUT
);

	// Second micro-op never holds fetch
	splitReleases: assert property (@(posedge clk) disable iff (reset)
		(uopStall && !stallUop) |=> !uopStall)
		else $error("uopStall still high after an unstalled first micro-op");

	// A stalling split always drives the micro-op path
	stallNeedsMux: assert property (@(posedge clk) disable iff (reset) uopStall |-> instrMux)
		else $error("uopStall high while instrMux is low");

	// Frozen decode stage keeps the phase
	phaseFrozen: assert property (@(posedge clk) disable iff (reset) stallUop |=> $stable(phase))
		else $error("phase changed on an edge with stallUop high");

endmodule

bind microOpUnit microOpUnitChecker splitChecks (
	.clk      (clk),
	.reset    (reset),
	.stallUop (stallUop),
	.uopStall (uopStall),
	.instrMux (instrMux),
	.phase    (phase)
);

`default_nettype wire

// File: testbench/uopModel.svh
// Reference model functions for class decode, micro-op word and control level prediction
`ifndef UOP_MODEL_SVH
`define UOP_MODEL_SVH

// Split class by priority of RSR, multiply-accumulate, BL and single load/store
function automatic uopKind modelKind(input logic [31:0] w);
	uopKind k;
	k = kindNone;
	if ((w[27:25] == 3'b000) && !w[7] && w[4]) begin
		k = kindRsr;
	end else if (w[21] && (w[7:4] == 4'b1001)) begin
		k = w[23] ? kindMulAccLong : kindMulAccShort;
	end else if (w[27:24] == 4'b1011) begin
		k = kindBranchLink;
	end else if (w[27:26] == 2'b01) begin
		case ({w[25:24], w[21]})                // I, P and W bits
			3'b000: k = kindLdStPostImm;
			3'b011: k = kindLdStPreImm;
			3'b100: k = kindLdStPostReg;
			3'b111: k = kindLdStPreReg;
			3'b110: k = w[20] ? kindNone : kindStrReg; // Stores only
			default: k = kindNone;
		endcase
	end
	return k;
endfunction

// Expected uopInstr for a class and half of the split
function automatic logic [31:0] modelWord(input uopKind k, input logic second,
	input logic [31:0] w);
	logic [31:0] u;
	dpOpcode addSub;
	addSub = w[23] ? opAdd : opSub;             // Direction from the U bit
	u = {w[31:28], 28'h0000000};                // Condition kept with other fields filled below
	case (k)
		kindRsr: begin
			if (!second) begin
				u[24:21] = opMov;               // MOV Rz, shifter operand
				u[15:0] = {4'hf, w[11:0]};
			end else begin
				u = {w[31:12], 12'h00f};        // Rz as plain Rm
			end
		end
		kindMulAccShort, kindMulAccLong: begin
			if (!second) begin
				u[22] = w[22];                  // Signed bit survives
				u[19:16] = 4'hf;
				u[11:0] = w[11:0];
			end else if (k == kindMulAccShort) begin
				u[24:16] = {opAdd, w[20], 4'hf}; // Rd = Rz + Rn
				u[15:12] = w[19:16];
				u[3:0] = w[15:12];
			end else begin
				u[23:20] = {1'b1, w[22], 1'b1, w[20]}; // Long form with A set
				u[19:0] = {w[19:16], w[15:12], w[15:12], 4'b1001, w[19:16]};
			end
		end
		kindBranchLink: begin
			if (!second) begin
				u[24:21] = opMov;               // LR = PC
				u[15:12] = 4'd14;
				u[3:0] = 4'd15;
			end else begin
				u = w;
				u[24] = 1'b0;                   // Plain branch
			end
		end
		kindLdStPostImm, kindLdStPostReg, kindLdStPreImm, kindLdStPreReg: begin
			if (second) begin
				u[25:21] = {~w[25], addSub};    // Base update with immediate bit inverted
				u[19:0] = {w[19:16], w[19:16], w[11:0]};
			end else if ((k == kindLdStPreImm) || (k == kindLdStPreReg)) begin
				u = w;
				u[24] = 1'b1;
				u[21] = 1'b0;                   // Writeback stripped
			end else begin
				u[27:20] = {5'b01011, w[22], 1'b0, w[20]}; // Zero-offset pre access
				u[19:12] = w[19:12];
			end
		end
		kindStrReg: begin
			if (!second) begin
				u[24:21] = addSub;              // Rz = Rn +/- Rm
				u[19:0] = {w[19:16], 4'hf, w[11:0]};
			end else begin
				u[27:16] = {3'b010, w[24:20], 4'hf};
				u[15:12] = w[15:12];
			end
		end
		default: u = w;
	endcase
	return u;
endfunction

// Controls as {noUpdateFlags, regFileRz, prevRsrState, keepV, noRotate, ldStRtype}
function automatic logic [8:0] modelControls(input uopKind k, input logic second);
	logic [8:0] c;
	case (k)
		kindRsr: c = second ? 9'b0_0010_1000 : 9'b1_1100_0000;
		kindMulAccShort: c = second ? 9'b1_0001_0000 : 9'b0_1100_0100;
		kindMulAccLong: c = second ? 9'b1_0000_0000 : 9'b0_1100_0100;
		kindLdStPostImm, kindLdStPreImm: c = 9'b1_0000_0010;
		kindLdStPostReg, kindLdStPreReg: c = 9'b1_0000_0011;
		kindStrReg: c = second ? 9'b1_0001_0000 : 9'b1_0100_0000;
		default: c = 9'b0_0000_0000;           // BL and unsplit words
	endcase
	return c;
endfunction

`endif

// File: testbench/microOpUnitTb.sv
// Testbench with clock, reset, seeded random stimulus, model checks, report and watchdog
`timescale 1ns/1ps
`default_nettype none

module microOpUnitTb;
	import uopPkg::*;

	localparam int numTests = 5;
	localparam int cyclesPerTest = 600;
	localparam int resetCycles = 16;
	localparam int watchdogNs = (numTests * cyclesPerTest + resetCycles) * 4 + 400; // Plus margin

	logic clk;
	logic reset;
	logic [31:0] instr;
	logic stallUop;
	logic [31:0] uopInstr;
	logic instrMux;
	logic noUpdateFlags;
	logic uopStall;
	logic [3:0] regFileRz;
	logic prevRsrState;
	logic keepV;
	logic noRotate;
	logic ldStRtype;

	integer seed;
	int errorCount;
	int checkCount;
	int testErrors;
	int splitCount;
	uopPhase modelPhase;                        // Model copy of the sequencer
	uopKind modelHeld;
	logic lastStall;                            // Values seen on the previous cycle
	logic lastUopStall;
	logic [31:0] lastWord;
	logic [10:0] lastCtl;
	string testNames [numTests] = '{"passThrough", "rsrAndBranchLink", "mulAccumulate",
		"loadStore", "stallMix"};

	`include "uopModel.svh"

	microOpUnit i_dut (
		.clk           (clk),
		.reset         (reset),
		.instr         (instr),
		.stallUop      (stallUop),
		.uopInstr      (uopInstr),
		.instrMux      (instrMux),
		.noUpdateFlags (noUpdateFlags),
		.uopStall      (uopStall),
		.regFileRz     (regFileRz),
		.prevRsrState  (prevRsrState),
		.keepV         (keepV),
		.noRotate      (noRotate),
		.ldStRtype     (ldStRtype)
	);

	always #2 clk = ~clk;                       // 4 ns period

	task automatic checkField(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		checkCount++;
		assert (actual === expected) else begin
			$display("** Error at %0d ns: %s expected %0h, got %0h", $time, name, expected, actual);
			errorCount++;
			testErrors++;
		end
	endtask

	// Class bias per test with codes 0 plain, 1 RSR, 2 MLA, 3 BL, 4 indexed ld/st, 5 register store
	function automatic int pickClass(input int testIdx);
		int r;
		r = $random(seed) & 7;
		case (testIdx)
			0: return 0;
			1: return (r < 4) ? 1 : ((r < 7) ? 3 : 0);
			2: return (r < 7) ? 2 : 0;
			3: return (r < 5) ? 4 : 5;
			default: return r % 6;
		endcase
	endfunction

	function automatic logic [31:0] drawInstr(input int pick);
		logic [31:0] w;
		logic [31:0] form;
		w = $random(seed);
		form = $random(seed);
		case (pick)
			1: begin
				w[27:25] = 3'b000;              // DP register form shifted by Rs
				w[7] = 1'b0;
				w[4] = 1'b1;
			end
			2: begin
				w[27:24] = 4'b0000;
				w[21] = 1'b1;                   // Accumulate with bit 23 left random
				w[7:4] = 4'b1001;
			end
			3: begin
				w[27:24] = 4'b1011;
				w[4] = 1'b0;                    // Keeps clear of the MLA pattern
			end
			4: begin
				w[27:26] = 2'b01;
				w[7] = 1'b0;
				case (form[1:0])
					2'b00: {w[25:24], w[21]} = 3'b000;
					2'b01: {w[25:24], w[21]} = 3'b011;
					2'b10: {w[25:24], w[21]} = 3'b100;
					default: {w[25:24], w[21]} = 3'b111;
				endcase
			end
			5: begin
				w[27:24] = 4'b0111;             // Register offset with pre-index
				w[21:20] = 2'b00;               // Store without writeback
				w[7] = 1'b0;
			end
			default: begin
				w[27:25] = 3'b111;              // Coprocessor space that never splits
				w[4] = 1'b0;
			end
		endcase
		return w;
	endfunction

	// One cycle drives on the falling edge, checks after settling and steps the model on the rise
	task automatic runCycle(input int testIdx);
		uopKind liveKind;
		uopKind activeKind;
		logic second;
		logic [8:0] expCtl;
		logic [10:0] actCtl;
		@(negedge clk);
		if (!lastUopStall && !lastStall) begin
			instr = drawInstr(pickClass(testIdx));
		end
		stallUop = (testIdx != 0) && (($random(seed) & 3) == 0); // About a quarter
		#1;
		second = (modelPhase == phaseSecond);
		liveKind = modelKind(instr);
		activeKind = second ? modelHeld : liveKind;
		expCtl = modelControls(activeKind, second);
		actCtl = {noUpdateFlags, regFileRz, prevRsrState, keepV, noRotate, ldStRtype,
			uopStall, instrMux};
		checkField("uopInstr", modelWord(activeKind, second, instr), uopInstr);
		checkField("uopStall", 32'(!second && (liveKind != kindNone)), 32'(uopStall));
		checkField("instrMux", 32'(activeKind != kindNone), 32'(instrMux));
		checkField("noUpdateFlags", 32'(expCtl[8]), 32'(noUpdateFlags));
		checkField("regFileRz", 32'(expCtl[7:4]), 32'(regFileRz));
		checkField("prevRsrState", 32'(expCtl[3]), 32'(prevRsrState));
		checkField("keepV", 32'(expCtl[2]), 32'(keepV));
		checkField("noRotate", 32'(expCtl[1]), 32'(noRotate));
		checkField("ldStRtype", 32'(expCtl[0]), 32'(ldStRtype));
		if (lastStall) begin
			checkField("uopInstr held by stallUop", lastWord, uopInstr); // Exact repeat
			checkField("controls held by stallUop", 32'(lastCtl), 32'(actCtl));
		end
		lastStall = stallUop;
		lastUopStall = uopStall;
		lastWord = uopInstr;
		lastCtl = actCtl;
		@(posedge clk);
		if (!stallUop) begin
			if (!second && (liveKind != kindNone)) begin
				modelPhase = phaseSecond;
				modelHeld = liveKind;
				splitCount++;
			end else if (second) begin
				modelPhase = phaseFirst;
			end
		end
	endtask

	initial begin
		clk = 1'b0;
		reset = 1'b1;
		instr = 32'h0;
		stallUop = 1'b0;
		seed = 32'hd39b375b;
		errorCount = 0;
		checkCount = 0;
		modelPhase = phaseFirst;
		modelHeld = kindNone;
		lastStall = 1'b0;
		lastUopStall = 1'b0;
		lastWord = 32'h0;
		lastCtl = 11'h0;
		repeat (resetCycles) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		for (int t = 0; t < numTests; t++) begin
			testErrors = 0;
			splitCount = 0;
			repeat (cyclesPerTest) runCycle(t);
			$display("Test %0d %s: %0d cycles, %0d splits, %0d errors", t, testNames[t],
				cyclesPerTest, splitCount, testErrors);
		end
		$display("Summary: %0d tests, %0d checks, %0d errors", numTests, checkCount, errorCount);
		if (errorCount == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

	// Watchdog sized from the total cycle count
	initial begin
		#(watchdogNs);
		$display("Watchdog expired at %0d ns before all tests finished", $time);
		$display("TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: flist.f
+incdir+testbench
rtl/uopPkg.sv
rtl/uopClassifier.sv
rtl/uopSequencer.sv
rtl/uopComposer.sv
rtl/microOpUnit.sv
testbench/microOpUnit_checker.sv
testbench/microOpUnitTb.sv

// File: run.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and looks for the pass message in the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module microOpUnitTb -f flist.f -o simMicroOpUnit

if ! ./obj_dir/simMicroOpUnit > sim.log 2>&1; then
	cat sim.log
	echo "Simulation exited with an error"
	exit 1
fi
cat sim.log

if grep -q "^TESTS PASSED$" sim.log; then
	exit 0
else
	exit 1
fi
